// File: cacheController.sv
`timescale 1ns/1ns
`default_nettype none

module cacheController (
  input  logic                              clk,
  input  logic                              reset,
  // core side
  input  logic                              req,
  input  logic                              we,
  input  cachePkg::accessSize               size,
  input  logic [cachePkg::addrWidth-1:0]    addr,
  input  logic [cachePkg::dataWidth-1:0]    wdata,
  output logic                              done,
  output logic [cachePkg::dataWidth-1:0]    rdata,
  output logic                              hit,
  // cache store
  input  logic                              hitValid,
  input  logic                              hitWay,
  input  logic [cachePkg::dataWidth-1:0]    hitData,
  input  logic                              victimWay,
  output logic [cachePkg::setBits-1:0]      lookupSet,
  output logic [cachePkg::tagBits-1:0]      lookupTag,
  output logic                              storeWe,
  output logic                              storeWay,
  output logic [cachePkg::setBits-1:0]      storeSet,
  output logic [cachePkg::tagBits-1:0]      storeTag,
  output logic [cachePkg::dataWidth-1:0]    storeData,
  output logic [cachePkg::bytesPerWord-1:0] storeByteEn,
  output logic                              touchEn,
  output logic [cachePkg::setBits-1:0]      touchSet,
  output logic                              touchWay,
  // main memory
  input  logic                              memAck,
  input  logic [cachePkg::dataWidth-1:0]    memRdata,
  output logic                              memReq,
  output logic                              memWe,
  output logic [cachePkg::addrWidth-1:0]    memAddr,
  output logic [cachePkg::dataWidth-1:0]    memWdata,
  output logic [cachePkg::bytesPerWord-1:0] memByteEn
);

  typedef enum logic [1:0] {idle, lookup, waitMem, refill} stateType;

  stateType                            state;
  logic [cachePkg::addrWidth-1:0]      reqAddr;
  logic                                reqWe;
  cachePkg::accessSize                 reqSize;
  logic [cachePkg::dataWidth-1:0]      reqWdata;
  logic [cachePkg::offsetBits-1:0]     reqOffset;
  logic [cachePkg::bytesPerWord-1:0]   byteEn;
  logic [cachePkg::dataWidth-1:0]      wordData;
  logic [cachePkg::dataWidth-1:0]      fillData;
  logic                                fillWay;
  logic [cachePkg::dataWidth-1:0]      rdataReg;
  logic                                hitReg;
  logic                                doneReg;
  logic                                memReqReg;

  // lbu picks one byte and zero-extends, lw passes the word
  function automatic logic [cachePkg::dataWidth-1:0] alignLoad(
    input logic [cachePkg::dataWidth-1:0]  word,
    input cachePkg::accessSize             sz,
    input logic [cachePkg::offsetBits-1:0] offset
  );
    logic [7:0] lane;
    lane = word[8*offset +: 8];
    if (sz == cachePkg::sizeByte) begin
      return {{(cachePkg::dataWidth-8){1'b0}}, lane};
    end
    return word;
  endfunction

  assign reqOffset = reqAddr[cachePkg::offsetBits-1:0];

  // sb writes one lane with the byte replicated, sw writes all four
  always_comb begin
    if (reqSize == cachePkg::sizeByte) begin
      byteEn            = '0;
      byteEn[reqOffset] = 1'b1;
      wordData          = {cachePkg::bytesPerWord{reqWdata[7:0]}};
    end else begin
      byteEn   = '1;
      wordData = reqWdata;
    end
  end

  assign lookupSet = reqAddr[cachePkg::offsetBits +: cachePkg::setBits];
  assign lookupTag = reqAddr[cachePkg::addrWidth-1 -: cachePkg::tagBits];
  assign storeSet  = lookupSet;
  assign storeTag  = lookupTag;
  assign touchSet  = lookupSet;
  assign touchWay  = storeWay;

  // store hit updates in lookup, refill writes the whole word
  always_comb begin
    storeWe     = 1'b0;
    storeWay    = hitWay;
    storeData   = wordData;
    storeByteEn = byteEn;
    touchEn     = 1'b0;
    case (state)
      lookup: begin
        if (hitValid) begin
          touchEn = 1'b1;           // load or store hit
          storeWe = reqWe;
        end
      end
      refill: begin
        storeWe     = 1'b1;
        storeWay    = fillWay;
        storeData   = fillData;
        storeByteEn = '1;
        touchEn     = 1'b1;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= idle;
      doneReg   <= 1'b0;
      memReqReg <= 1'b0;
    end else begin
      doneReg   <= 1'b0;
      memReqReg <= 1'b0;
      case (state)
        idle: begin
          if (req) begin
            state <= lookup;
          end
        end
        lookup: begin
          if (hitValid && !reqWe) begin
            doneReg <= 1'b1;        // load hit answers straight away
            state   <= idle;
          end else begin
            memReqReg <= 1'b1;      // load miss or write-through
            state     <= waitMem;
          end
        end
        waitMem: begin
          if (memAck) begin
            doneReg <= !reqWe;
            state   <= reqWe ? idle : refill;
          end
        end
        default: state <= idle;     // refill lasts one cycle
      endcase
    end
  end

  // request and response payload
  always_ff @(posedge clk) begin
    if (state == idle && req) begin
      reqAddr  <= addr;
      reqWe    <= we;
      reqSize  <= size;
      reqWdata <= wdata;
    end
    if (state == lookup) begin
      hitReg   <= hitValid;
      fillWay  <= victimWay;
      rdataReg <= alignLoad(hitData, reqSize, reqOffset);
    end
    if (state == waitMem && memAck) begin
      fillData <= memRdata;
      rdataReg <= alignLoad(memRdata, reqSize, reqOffset);
    end
  end

  // stores finish together with the memory ack
  assign done  = doneReg | (state == waitMem && memAck && reqWe);
  assign rdata = rdataReg;
  assign hit   = hitReg;

  assign memReq    = memReqReg;
  assign memWe     = reqWe;
  assign memAddr   = {reqAddr[cachePkg::addrWidth-1:cachePkg::offsetBits],
                      {cachePkg::offsetBits{1'b0}}};
  assign memWdata  = wordData;
  assign memByteEn = byteEn;

endmodule

`default_nettype wire

// File: cachePkg.sv
`default_nettype none

package cachePkg;

  // byte address split: tag | set | byte offset
  localparam int addrWidth = 32;
  localparam int dataWidth = 32;
  localparam int bytesPerWord = dataWidth / 8;

  // cache geometry
  localparam int setNum = 8;
  localparam int setBits = 3;                  // set index, addr[4:2]
  localparam int wayNum = 2;
  localparam int offsetBits = 2;               // byte in word, addr[1:0]
  localparam int tagBits = addrWidth - setBits - offsetBits;  // addr[31:5]

  // backing memory
  localparam int memWords = 256;
  localparam int memAddrBits = $clog2(memWords);       // word index from addr[9:2]
  localparam int memLatency = 4;                       // req to ack, in cycles
  localparam int latCntBits = $clog2(memLatency + 1);

  // load/store width
  typedef enum logic {
    sizeWord = 1'b0,  // lw / sw
    sizeByte = 1'b1   // lbu / sb
  } accessSize;

  // power-up contents of word idx, every byte equals idx
  function automatic logic [dataWidth-1:0] initWord(input int unsigned idx);
    logic [dataWidth-1:0] pattern;
    pattern = dataWidth'(idx * 32'h0101_0101);
    return pattern;
  endfunction

endpackage

`default_nettype wire

// File: cacheStore.sv
`timescale 1ns/1ns
`default_nettype none

module cacheStore (
  input  logic                              clk,
  input  logic                              reset,
  // lookup side
  input  logic [cachePkg::setBits-1:0]      lookupSet,
  input  logic [cachePkg::tagBits-1:0]      lookupTag,
  // write side
  input  logic                              storeWe,
  input  logic                              storeWay,
  input  logic [cachePkg::setBits-1:0]      storeSet,
  input  logic [cachePkg::tagBits-1:0]      storeTag,
  input  logic [cachePkg::dataWidth-1:0]    storeData,
  input  logic [cachePkg::bytesPerWord-1:0] storeByteEn,
  // LRU update
  input  logic                              touchEn,
  input  logic [cachePkg::setBits-1:0]      touchSet,
  input  logic                              touchWay,
  // lookup result
  output logic                              hitValid,
  output logic                              hitWay,
  output logic [cachePkg::dataWidth-1:0]    hitData,
  output logic                              victimWay
);

  logic [cachePkg::wayNum-1:0]    validBits [cachePkg::setNum];
  logic [cachePkg::tagBits-1:0]   tagArr    [cachePkg::setNum][cachePkg::wayNum];
  logic [cachePkg::dataWidth-1:0] dataArr   [cachePkg::setNum][cachePkg::wayNum];
  logic [cachePkg::setNum-1:0]    lru;       // per set, names the least recently used way
  logic [cachePkg::wayNum-1:0]    wayMatch;

  // compare both ways of the addressed set
  always_comb begin
    for (int w = 0; w < cachePkg::wayNum; w++) begin
      wayMatch[w] = validBits[lookupSet][w] && (tagArr[lookupSet][w] == lookupTag);
    end
  end

  assign hitValid = |wayMatch;
  assign hitWay   = wayMatch[1];                  // only meaningful with hitValid
  assign hitData  = dataArr[lookupSet][hitWay];

  // victim for a refill
  always_comb begin
    if (!validBits[lookupSet][0]) begin
      victimWay = 1'b0;                           // empty way 0 first
    end else if (!validBits[lookupSet][1]) begin
      victimWay = 1'b1;
    end else begin
      victimWay = lru[lookupSet];                 // both full, evict the LRU way
    end
  end

  // tag and data arrays
  always_ff @(posedge clk) begin
    if (storeWe) begin
      tagArr[storeSet][storeWay] <= storeTag;
      for (int b = 0; b < cachePkg::bytesPerWord; b++) begin
        if (storeByteEn[b]) begin
          dataArr[storeSet][storeWay][8*b +: 8] <= storeData[8*b +: 8];  // per byte lane
        end
      end
    end
  end

  // valid and LRU state
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < cachePkg::setNum; s++) begin
        validBits[s] <= '0;
      end
      lru <= '0;
    end else begin
      if (storeWe) begin
        validBits[storeSet][storeWay] <= 1'b1;
      end
      // the way just used becomes MRU, so the other one is LRU
      if (touchEn) begin
        lru[touchSet] <= ~touchWay;
      end
    end
  end

endmodule

`default_nettype wire

// File: dataCacheTb.sv
`timescale 1ns/1ns
`default_nettype none

module dataCacheTb;

  localparam int clkPeriod = 4;
  localparam int directedOps = 25;  // hand-written accesses below
  localparam int randomOps = 300;
  localparam int opCount = directedOps + randomOps;
  localparam int timeoutNs = opCount * (cachePkg::memLatency + 6) * clkPeriod + 2000;

  logic                           clk;
  logic                           reset;
  logic                           req;
  logic                           we;
  cachePkg::accessSize            size;
  logic [cachePkg::addrWidth-1:0] addr;
  logic [cachePkg::dataWidth-1:0] wdata;
  logic                           done;
  logic [cachePkg::dataWidth-1:0] rdata;
  logic                           hit;

  // reference model of memory and cache state
  logic [cachePkg::dataWidth-1:0] refMem   [cachePkg::memWords];
  logic [cachePkg::wayNum-1:0]    refValid [cachePkg::setNum];
  logic [cachePkg::tagBits-1:0]   refTag   [cachePkg::setNum][cachePkg::wayNum];
  logic [cachePkg::setNum-1:0]    refLru;
  int                             seed;

  dataCacheTop UUT (.*);

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  initial begin
    #(timeoutNs);
    $display("watchdog expired before all accesses completed");
    $display("Checks failed");
    $fatal(1, "simulation stopped by watchdog");
  end

  task automatic reportMismatch(input string msg);
    $display("[ERROR] %0t ns: %s", $time, msg);
    $display("Checks failed");
    $fatal(1, "stopped at first mismatch");
  endtask

  // one core access that updates the model, drives the request and checks at done
  task automatic access(input logic isStore, input cachePkg::accessSize sz,
                        input logic [31:0] a, input logic [31:0] wd);
    logic [2:0]  setIdx;
    logic [7:0]  wordIdx;
    logic [26:0] tg;
    logic        expHit;
    logic        hitWay;
    logic        fillWay;
    logic [31:0] expData;
    int          cycles;
    int          expCycles;
    setIdx  = a[4:2];
    wordIdx = a[9:2];
    tg      = a[31:5];
    expHit  = 1'b0;
    hitWay  = 1'b0;
    if (refValid[setIdx][0] && refTag[setIdx][0] == tg) begin
      expHit = 1'b1;
    end else if (refValid[setIdx][1] && refTag[setIdx][1] == tg) begin
      expHit = 1'b1;
      hitWay = 1'b1;
    end
    if (isStore) begin
      if (sz == cachePkg::sizeByte) begin
        refMem[wordIdx][8*a[1:0] +: 8] = wd[7:0];
      end else begin
        refMem[wordIdx] = wd;
      end
      if (expHit) refLru[setIdx] = ~hitWay;   // store miss leaves LRU alone
      expCycles = cachePkg::memLatency + 2;
    end else if (expHit) begin
      refLru[setIdx] = ~hitWay;
      expCycles = 2;
    end else begin
      // first empty way or else the LRU way
      if (!refValid[setIdx][0]) fillWay = 1'b0;
      else if (!refValid[setIdx][1]) fillWay = 1'b1;
      else fillWay = refLru[setIdx];
      refValid[setIdx][fillWay] = 1'b1;
      refTag[setIdx][fillWay]   = tg;
      refLru[setIdx]            = ~fillWay;
      expCycles = cachePkg::memLatency + 3;
    end
    expData = refMem[wordIdx];
    if (sz == cachePkg::sizeByte) expData = {24'd0, expData[8*a[1:0] +: 8]};

    @(posedge clk);
    #1;
    req   = 1'b1;
    we    = isStore;
    size  = sz;
    addr  = a;
    wdata = wd;
    @(posedge clk);
    #1;
    req    = 1'b0;
    cycles = 1;
    @(negedge clk);
    while (!done) begin
      @(negedge clk);
      cycles++;
    end

    assert (cycles == expCycles) else reportMismatch($sformatf(
      "addr %h: done after %0d cycles, expected %0d", a, cycles, expCycles));
    assert (hit == expHit) else reportMismatch($sformatf(
      "addr %h: hit expected %0b, observed %0b", a, expHit, hit));
    if (!isStore) begin
      assert (rdata == expData) else reportMismatch($sformatf(
        "addr %h: rdata expected %h, observed %h", a, expData, rdata));
    end
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] randData;
    logic [4:0]  tagVal;
    logic [1:0]  off;
    seed  = 51;
    reset = 1'b1;
    req   = 1'b0;
    we    = 1'b0;
    size  = cachePkg::sizeWord;
    addr  = '0;
    wdata = '0;
    for (int i = 0; i < cachePkg::memWords; i++) begin
      refMem[i] = i * 32'h0101_0101;     // every byte of word i is i
    end
    for (int s = 0; s < cachePkg::setNum; s++) begin
      refValid[s] = '0;
    end
    refLru = '0;

    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    repeat (3) begin
      @(negedge clk);
      assert (!done) else reportMismatch("done high before any request");
    end

    // cold miss then hit on the same word
    access(1'b0, cachePkg::sizeWord, 32'h40, 32'h0);
    access(1'b0, cachePkg::sizeWord, 32'h40, 32'h0);

    // byte loads on all offsets around sw and sb hits
    access(1'b0, cachePkg::sizeWord, 32'h48, 32'h0);
    access(1'b1, cachePkg::sizeWord, 32'h48, 32'hA1B2_C3D4);
    for (int o = 0; o < 4; o++) begin
      access(1'b0, cachePkg::sizeByte, 32'h48 + o, 32'h0);
    end
    access(1'b1, cachePkg::sizeByte, 32'h49, 32'h0000_00F7);  // top bit set
    access(1'b0, cachePkg::sizeByte, 32'h49, 32'h0);
    access(1'b0, cachePkg::sizeWord, 32'h48, 32'h0);

    // push 0x48 out of set 2 so the reload shows memory got the stores
    access(1'b0, cachePkg::sizeWord, 32'h68, 32'h0);
    access(1'b0, cachePkg::sizeWord, 32'h88, 32'h0);
    access(1'b0, cachePkg::sizeWord, 32'h48, 32'h0);

    // store misses do not allocate
    access(1'b1, cachePkg::sizeWord, 32'h100, 32'h1234_5678);
    access(1'b0, cachePkg::sizeWord, 32'h100, 32'h0);
    access(1'b1, cachePkg::sizeByte, 32'h206, 32'h0000_009C);
    access(1'b0, cachePkg::sizeByte, 32'h206, 32'h0);
    access(1'b0, cachePkg::sizeWord, 32'h204, 32'h0);

    // A, B, A, C in set 3 evicts B
    access(1'b0, cachePkg::sizeWord, 32'h0C, 32'h0);
    access(1'b0, cachePkg::sizeWord, 32'h2C, 32'h0);
    access(1'b0, cachePkg::sizeWord, 32'h0C, 32'h0);
    access(1'b0, cachePkg::sizeWord, 32'h4C, 32'h0);
    access(1'b0, cachePkg::sizeWord, 32'h0C, 32'h0);   // A still cached
    access(1'b0, cachePkg::sizeWord, 32'h2C, 32'h0);   // B gone

    // random mix over 3 tags per set
    for (int n = 0; n < randomOps; n++) begin
      r        = $random(seed);
      randData = $random(seed);
      if (r[6:5] == 2'd0) tagVal = 5'd0;
      else if (r[6:5] == 2'd1) tagVal = 5'd11;
      else tagVal = 5'd22;
      off = r[8] ? r[11:10] : 2'b00;      // byte ops only use the offset
      access(r[9], r[8] ? cachePkg::sizeByte : cachePkg::sizeWord,
             {22'd0, tagVal, r[4:2], off}, randData);
    end

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: dataCacheTop.sv
`timescale 1ns/1ns
`default_nettype none

module dataCacheTop (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           req,
  input  logic                           we,
  input  cachePkg::accessSize            size,
  input  logic [cachePkg::addrWidth-1:0] addr,
  input  logic [cachePkg::dataWidth-1:0] wdata,
  output logic                           done,
  output logic [cachePkg::dataWidth-1:0] rdata,
  output logic                           hit
);

  // controller to store
  logic [cachePkg::setBits-1:0]      lookupSet;
  logic [cachePkg::tagBits-1:0]      lookupTag;
  logic                              hitValid;
  logic                              hitWay;
  logic [cachePkg::dataWidth-1:0]    hitData;
  logic                              victimWay;
  logic                              storeWe;
  logic                              storeWay;
  logic [cachePkg::setBits-1:0]      storeSet;
  logic [cachePkg::tagBits-1:0]      storeTag;
  logic [cachePkg::dataWidth-1:0]    storeData;
  logic [cachePkg::bytesPerWord-1:0] storeByteEn;
  logic                              touchEn;
  logic [cachePkg::setBits-1:0]      touchSet;
  logic                              touchWay;

  // controller to memory
  logic                              memReq;
  logic                              memWe;
  logic [cachePkg::addrWidth-1:0]    memAddr;
  logic [cachePkg::dataWidth-1:0]    memWdata;
  logic [cachePkg::bytesPerWord-1:0] memByteEn;
  logic                              memAck;
  logic [cachePkg::dataWidth-1:0]    memRdata;

  // all port names match the nets above
  cacheController controller (.*);

  cacheStore store (.*);

  mainMemory memory (.*);

endmodule

`default_nettype wire

// File: flist.f
cachePkg.sv
cacheStore.sv
mainMemory.sv
cacheController.sv
dataCacheTop.sv
dataCacheTb.sv

// File: mainMemory.sv
`timescale 1ns/1ns
`default_nettype none

module mainMemory (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              memReq,
  input  logic                              memWe,
  input  logic [cachePkg::addrWidth-1:0]    memAddr,
  input  logic [cachePkg::dataWidth-1:0]    memWdata,
  input  logic [cachePkg::bytesPerWord-1:0] memByteEn,
  output logic                              memAck,
  output logic [cachePkg::dataWidth-1:0]    memRdata
);

  logic [cachePkg::dataWidth-1:0]   mem [cachePkg::memWords];
  logic [cachePkg::memAddrBits-1:0] wordIdx;
  logic                             busy;
  logic [cachePkg::latCntBits-1:0]  delayCnt;

  assign wordIdx = memAddr[cachePkg::offsetBits +: cachePkg::memAddrBits];  // higher bits alias

  initial begin
    for (int i = 0; i < cachePkg::memWords; i++) begin
      mem[i] = cachePkg::initWord(i);
    end
  end

  // access happens when the request arrives, the ack only comes later
  always @(posedge clk) begin
    if (memReq) begin
      if (memWe) begin
        for (int b = 0; b < cachePkg::bytesPerWord; b++) begin
          if (memByteEn[b]) begin
            mem[wordIdx][8*b +: 8] <= memWdata[8*b +: 8];
          end
        end
      end else begin
        memRdata <= mem[wordIdx];   // held until the ack
      end
    end
  end

  // latency counter
  always_ff @(posedge clk) begin
    if (reset) begin
      busy     <= 1'b0;
      delayCnt <= '0;
      memAck   <= 1'b0;
    end else begin
      memAck <= 1'b0;
      if (memReq) begin
        busy     <= 1'b1;
        delayCnt <= cachePkg::latCntBits'(cachePkg::memLatency - 1);
      end else if (busy) begin
        delayCnt <= delayCnt - 1'b1;
        if (delayCnt == 1) begin
          memAck <= 1'b1;           // lands memLatency cycles after memReq
          busy   <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: runSim.sh
#!/usr/bin/env bash
# build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module dataCacheTb -f flist.f -Mdir objDir
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

output=$(./objDir/VdataCacheTb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "All checks passed" <<< "$output"; then
  exit 0
fi
exit 1
